/* gpu_global_pkg.sv */
//////////////////////////////////////////////////////////////////////
// GPU wide definitions shared by every unit on the request bus.
// Holds the master id encoding and the bus data width. Units import
// it inside their body and use scoped names in their port lists.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package gpu_global_pkg;

  // Requesting master on the internal bus
  typedef enum logic [1:0]
  {
    MID_IDLE = 2'd0,  // No request, no response
    MID_RAST = 2'd1,  // Rasterizer
    MID_TEX  = 2'd2,  // Texture unit
    MID_HOST = 2'd3   // Host port
  } mid_t;

  // Request and response data word
  localparam int P_BUS_W = 32;

endpackage

`default_nettype wire

/* gpu_div_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Divide unit definitions: request opcodes and execute stage states.
// Imported by the decode and execute stages of the divider.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package gpu_div_pkg;

  // Divide operation carried with each request
  typedef enum logic
  {
    OP_DIVU = 1'b0,   // Unsigned
    OP_DIVS = 1'b1    // Signed, truncating toward zero
  } gpu_div_op_t;

  // Iterative divider FSM
  typedef enum logic [1:0]
  {
    DIV_IDLE = 2'd0,  // Waiting for load
    DIV_RUN  = 2'd1,  // Two quotient bits per cycle
    DIV_DONE = 2'd2   // One cycle to raise done
  } div_state_t;

endpackage

`default_nettype wire

/* gpu_div_intf.sv */
//////////////////////////////////////////////////////////////////////
// Internal link between the decode, execute and result stages.
// Operand magnitudes and sign flags flow forward from decode, the
// unsigned answer from execute, and rsp_fire back to decode.
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface gpu_div_intf #(
  parameter int DATA_W = 16
);
  import gpu_global_pkg::*;

  logic              load;      // Start pulse to execute
  logic [DATA_W-1:0] num_mag;   // Dividend magnitude
  logic [DATA_W-1:0] den_mag;   // Divisor magnitude
  logic              q_neg;     // Quotient must be negated
  logic              r_neg;     // Remainder must be negated
  mid_t              mid;       // Captured master id
  logic              done;      // Execute finished
  logic [DATA_W-1:0] quo_mag;
  logic [DATA_W-1:0] rem_mag;
  logic              rsp_fire;  // Response going out, frees decode

  modport decode (
    output load, num_mag, den_mag, q_neg, r_neg, mid,
    input  rsp_fire
  );

  modport execute (
    input  load, num_mag, den_mag,
    output done, quo_mag, rem_mag
  );

  modport result (
    input  done, quo_mag, rem_mag, q_neg, r_neg, mid, den_mag,
    output rsp_fire
  );

endinterface

`default_nettype wire

/* gpu_div_decode.sv */
//////////////////////////////////////////////////////////////////////
// Decode stage of the divide unit. Accepts one request when the
// master id is non-idle and busy is low, splits the operand word,
// turns signed operands into magnitudes plus sign flags and fires
// load one cycle later. busy holds until the response goes out.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module gpu_div_decode #(
  parameter int DATA_W = 16
)(
  input  logic                          cr_intf,
  input  logic                          reset,
  input  gpu_global_pkg::mid_t          req_mid,
  input  gpu_div_pkg::gpu_div_op_t      req_op,
  input  logic [gpu_global_pkg::P_BUS_W-1:0] req_data,
  output logic                          busy,
  gpu_div_intf.decode                   div
);
  import gpu_global_pkg::*;
  import gpu_div_pkg::*;

  logic              req_valid;
  logic [DATA_W-1:0] dividend;
  logic [DATA_W-1:0] divisor;
  logic              num_neg;
  logic              den_neg;

  // Requests seen while busy are simply dropped
  assign req_valid = (req_mid != MID_IDLE) && !busy;

  assign dividend  = req_data[P_BUS_W-1 -: DATA_W];  // Upper half
  assign divisor   = req_data[DATA_W-1:0];           // Lower half

  // Sign bits only count for the signed opcode
  assign num_neg   = (req_op == OP_DIVS) && dividend[DATA_W-1];
  assign den_neg   = (req_op == OP_DIVS) && divisor[DATA_W-1];

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      busy     <= 1'b0;
      div.load <= 1'b0;
    end
    else
    begin
      div.load <= req_valid;  // Start execute one cycle after accept
      if (req_valid)
        busy <= 1'b1;
      else if (div.rsp_fire)
        busy <= 1'b0;         // Falls with the rsp_mid pulse
    end
  end

  // Operand capture, stable until the next accepted request
  always_ff @(posedge cr_intf)
  begin
    if (req_valid)
    begin
      div.mid     <= req_mid;
      // Most negative value maps onto itself, which is its magnitude
      div.num_mag <= num_neg ? -dividend : dividend;
      div.den_mag <= den_neg ? -divisor : divisor;
      div.q_neg   <= num_neg ^ den_neg;  // Signs differ
      div.r_neg   <= num_neg;            // Remainder follows dividend
    end
  end

endmodule

`default_nettype wire

/* gpu_div_execute.sv */
//////////////////////////////////////////////////////////////////////
// Execute stage of the divide unit. Radix-4 restoring divider on
// unsigned magnitudes, two quotient bits per cycle, DATA_W/2 cycles
// per divide. A zero divisor runs through unchanged and leaves an
// all ones quotient with the dividend as remainder.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module gpu_div_execute #(
  parameter int DATA_W = 16
)(
  input  logic         cr_intf,
  input  logic         reset,
  gpu_div_intf.execute div
);
  import gpu_div_pkg::*;

  localparam int ITER  = DATA_W / 2;     // Radix-4 steps
  localparam int CNT_W = $clog2(ITER);

  div_state_t        state;
  logic [CNT_W-1:0]  cnt;                // Step counter
  logic [DATA_W-1:0] rem_q;              // Partial remainder
  logic [DATA_W-1:0] quo_q;              // Dividend bits out, quotient bits in
  logic [DATA_W+1:0] r_sh;               // Remainder with next two bits
  logic [DATA_W+1:0] d1;
  logic [DATA_W+1:0] d2;
  logic [DATA_W+1:0] d3;
  logic [1:0]        digit;
  logic [DATA_W+1:0] r_nxt;

  assign r_sh = {rem_q, quo_q[DATA_W-1 -: 2]};
  assign d1   = {2'b00, div.den_mag};
  assign d2   = {1'b0, div.den_mag, 1'b0};
  assign d3   = d1 + d2;                 // Fits, den is at most DATA_W bits

  // Largest multiple that still fits gives the digit
  always_comb
  begin
    if (r_sh >= d3)
    begin
      digit = 2'd3;
      r_nxt = r_sh - d3;
    end
    else if (r_sh >= d2)
    begin
      digit = 2'd2;
      r_nxt = r_sh - d2;
    end
    else if (r_sh >= d1)
    begin
      digit = 2'd1;
      r_nxt = r_sh - d1;
    end
    else
    begin
      digit = 2'd0;
      r_nxt = r_sh;
    end
  end

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      state    <= DIV_IDLE;
      cnt      <= '0;
      div.done <= 1'b0;
    end
    else
    begin
      div.done <= 1'b0;
      case (state)
        DIV_IDLE:
        begin
          cnt <= '0;
          if (div.load)
            state <= DIV_RUN;
        end
        DIV_RUN:
        begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(ITER - 1))
            state <= DIV_DONE;           // Last two bits retired
        end
        DIV_DONE:
        begin
          div.done <= 1'b1;              // Single cycle pulse
          state    <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge cr_intf)
  begin
    if (state == DIV_IDLE && div.load)
    begin
      rem_q <= '0;
      quo_q <= div.num_mag;
    end
    else if (state == DIV_RUN)
    begin
      // With a zero divisor r_nxt exceeds DATA_W, low bits rebuild the dividend
      rem_q <= r_nxt[DATA_W-1:0];
      quo_q <= {quo_q[DATA_W-3:0], digit};
    end
  end

  assign div.quo_mag = quo_q;
  assign div.rem_mag = rem_q;

endmodule

`default_nettype wire

/* gpu_div_result.sv */
//////////////////////////////////////////////////////////////////////
// Result stage of the divide unit. Restores the signs of quotient
// and remainder, flags a zero divisor, packs the response word and
// returns the master id as a one cycle pulse.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module gpu_div_result #(
  parameter int DATA_W = 16
)(
  input  logic                               cr_intf,
  input  logic                               reset,
  output gpu_global_pkg::mid_t               rsp_mid,
  output logic [gpu_global_pkg::P_BUS_W-1:0] rsp_data,
  output logic                               rsp_div_zero,
  gpu_div_intf.result                        div
);
  import gpu_global_pkg::*;

  logic              div_zero;
  logic [DATA_W-1:0] quo_fix;
  logic [DATA_W-1:0] rem_fix;

  assign div_zero = (div.den_mag == '0);

  // All ones quotient stays raw on a zero divisor
  assign quo_fix = (div.q_neg && !div_zero) ? -div.quo_mag : div.quo_mag;
  // Raw remainder is the dividend magnitude there, so the sign fix gives the dividend back
  assign rem_fix = div.r_neg ? -div.rem_mag : div.rem_mag;

  assign div.rsp_fire = div.done;  // Decode drops busy on the same edge

  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      rsp_mid      <= MID_IDLE;
      rsp_div_zero <= 1'b0;
    end
    else
    begin
      rsp_mid <= div.done ? div.mid : MID_IDLE;  // One cycle only
      if (div.done)
        rsp_div_zero <= div_zero;                 // Held until next response
    end
  end

  // Quotient high, remainder low
  always_ff @(posedge cr_intf)
  begin
    if (div.done)
      rsp_data <= {quo_fix, rem_fix};
  end

endmodule

`default_nettype wire

/* gpu_div_top.sv */
//////////////////////////////////////////////////////////////////////
// Integer divide unit of the GPU request bus. Joins the decode,
// execute and result stages through one internal interface and
// exposes plain bus ports. DATA_W is half the bus width.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module gpu_div_top #(
  parameter int DATA_W = 16              // Even, radix-4 divider
)(
  input  logic                               cr_intf,
  input  logic                               reset,
  input  gpu_global_pkg::mid_t               req_mid,
  input  gpu_div_pkg::gpu_div_op_t           req_op,
  input  logic [gpu_global_pkg::P_BUS_W-1:0] req_data,  // Dividend high, divisor low
  output logic                               busy,
  output gpu_global_pkg::mid_t               rsp_mid,
  output logic [gpu_global_pkg::P_BUS_W-1:0] rsp_data,  // Quotient high, remainder low
  output logic                               rsp_div_zero
);

  gpu_div_intf #(.DATA_W(DATA_W)) div_if ();

  gpu_div_decode #(.DATA_W(DATA_W)) u_decode (
    .cr_intf  (cr_intf),
    .reset    (reset),
    .req_mid  (req_mid),
    .req_op   (req_op),
    .req_data (req_data),
    .busy     (busy),
    .div      (div_if.decode)
  );

  gpu_div_execute #(.DATA_W(DATA_W)) u_execute (
    .cr_intf (cr_intf),
    .reset   (reset),
    .div     (div_if.execute)
  );

  gpu_div_result #(.DATA_W(DATA_W)) u_result (
    .cr_intf      (cr_intf),
    .reset        (reset),
    .rsp_mid      (rsp_mid),
    .rsp_data     (rsp_data),
    .rsp_div_zero (rsp_div_zero),
    .div          (div_if.result)
  );

endmodule

`default_nettype wire

/* gpu_div_assertions.sv */
//////////////////////////////////////////////////////////////////////
// Protocol assertions for the divide unit, bound into the top level.
// Cover the response pulse, the busy window and dropped requests.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module gpu_div_assertions (
  input logic                 cr_intf,
  input logic                 reset,
  input gpu_global_pkg::mid_t req_mid,
  input logic                 busy,
  input gpu_global_pkg::mid_t rsp_mid
);
  timeunit 1ns;
  timeprecision 1ps;
  import gpu_global_pkg::*;

  logic accept;
  mid_t acc_mid;  // Master of the last accepted request

  assign accept = (req_mid != MID_IDLE) && !busy;  // Same rule as decode

  always_ff @(posedge cr_intf)
  begin
    if (reset)
      acc_mid <= MID_IDLE;
    else if (accept)
      acc_mid <= req_mid;
  end

  rsp_one_cycle: assert property (@(posedge cr_intf) disable iff (reset)
    (rsp_mid != MID_IDLE) |=> (rsp_mid == MID_IDLE))
    else $error("rsp_mid held non-idle for more than one cycle");

  busy_fall_on_rsp: assert property (@(posedge cr_intf) disable iff (reset)
    $fell(busy) |-> (rsp_mid != MID_IDLE))
    else $error("busy fell without a response");

  rsp_drops_busy: assert property (@(posedge cr_intf) disable iff (reset)
    (rsp_mid != MID_IDLE) |-> $fell(busy))
    else $error("response while busy did not fall");

  // Response registered 11 edges after accept, sampled one edge later
  accept_to_rsp: assert property (@(posedge cr_intf) disable iff (reset)
    accept |-> ##12 (rsp_mid != MID_IDLE))
    else $error("accepted request got no response in 11 cycles");

  // Request seen while busy must not take over the pending response
  busy_req_dropped: assert property (@(posedge cr_intf) disable iff (reset)
    (rsp_mid != MID_IDLE) |-> (rsp_mid == acc_mid))
    else $error("response carries the master id of a dropped request");

endmodule

bind gpu_div_top gpu_div_assertions u_assertions (
  .cr_intf (cr_intf),
  .reset   (reset),
  .req_mid (req_mid),
  .busy    (busy),
  .rsp_mid (rsp_mid)
);

`default_nettype wire

/* tb_gpu_div.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the GPU integer divide unit. Directed tests drive
// requests on the plain bus ports and compare every response with a
// reference divide model, including latency and the busy window.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_gpu_div;
  timeunit 1ns;
  timeprecision 1ps;
  import gpu_global_pkg::*;
  import gpu_div_pkg::*;

  localparam int DATA_W      = P_BUS_W / 2;
  localparam int RSP_LATENCY = 11;        // Accept edge to response edge
  localparam int RSP_LIMIT   = 20;        // Per request wait
  localparam int N_REQ       = 64;        // Requests over all tests, rounded up
  localparam int TIMEOUT_CYC = N_REQ * RSP_LATENCY + N_REQ * 4 + 200;

  logic               cr_intf;
  logic               reset;
  mid_t               req_mid;
  gpu_div_op_t        req_op;
  logic [P_BUS_W-1:0] req_data;
  logic               busy;
  mid_t               rsp_mid;
  logic [P_BUS_W-1:0] rsp_data;
  logic               rsp_div_zero;
  int                 n_checks  = 0;
  int                 n_errors  = 0;
  int                 n_tests   = 0;
  int                 cycle_cnt = 0;

  gpu_div_top #(.DATA_W(DATA_W)) u_gpu_div_top (.*);

  initial
  begin
    cr_intf = 1'b0;
    forever #5 cr_intf = ~cr_intf;  // 10 ns period
  end

  always @(posedge cr_intf)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Reference divide model
  function automatic logic [P_BUS_W-1:0] expected_word(gpu_div_op_t op,
                                                       logic [DATA_W-1:0] a,
                                                       logic [DATA_W-1:0] b);
    int                sa;
    int                sb;
    logic [DATA_W-1:0] qw;
    logic [DATA_W-1:0] rw;
    if (b == '0)
      return {{DATA_W{1'b1}}, a};  // All ones, dividend kept
    if (op == OP_DIVU)
    begin
      qw = a / b;
      rw = a % b;
    end
    else
    begin
      sa = int'($signed(a));       // Wide enough for the overflow case
      sb = int'($signed(b));
      qw = DATA_W'(sa / sb);       // Truncates toward zero
      rw = DATA_W'(sa % sb);       // Sign of the dividend
    end
    return {qw, rw};
  endfunction

  function automatic mid_t pick_mid(int unsigned n);
    case (n % 3)
      0:       return MID_RAST;
      1:       return MID_TEX;
      default: return MID_HOST;
    endcase
  endfunction

  task automatic check_mid(string what, mid_t got, mid_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0t: %s expected %s got %s", $time, what, exp.name(), got.name());
    end
  endtask

  task automatic check_word(string what, logic [P_BUS_W-1:0] got, logic [P_BUS_W-1:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_latency(string what, int got);
    n_checks++;
    if (got != RSP_LATENCY)
    begin
      n_errors++;
      $display("mismatch at %0t: %s latency expected %0d got %0d", $time, what, RSP_LATENCY,
               got);
    end
  endtask

  // Held one cycle, returns right after the accepting edge
  task automatic issue_request(mid_t mid, gpu_div_op_t op, logic [P_BUS_W-1:0] data);
    @(posedge cr_intf);
    req_mid  <= mid;
    req_op   <= op;
    req_data <= data;
    @(posedge cr_intf);
    req_mid  <= MID_IDLE;
  endtask

  task automatic wait_response(output int latency, output logic found);
    latency = 0;
    @(negedge cr_intf);          // State after the accepting edge
    while (rsp_mid == MID_IDLE && latency < RSP_LIMIT)
    begin
      latency++;
      @(negedge cr_intf);
    end
    found = (rsp_mid != MID_IDLE);
  endtask

  task automatic run_request(string what, mid_t mid, gpu_div_op_t op,
                             logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    int   latency;
    logic found;
    issue_request(mid, op, {a, b});
    wait_response(latency, found);
    if (!found)
    begin
      n_errors++;
      $display("No response to the %s request within %0d cycles", what, RSP_LIMIT);
    end
    else
    begin
      check_latency(what, latency);
      check_mid(what, rsp_mid, mid);
      check_word(what, rsp_data, expected_word(op, a, b));
      check_flag(what, rsp_div_zero, b == '0);
    end
  endtask

  task automatic run_signed(mid_t mid, int a, int b);
    run_request("signed", mid, OP_DIVS, DATA_W'(a), DATA_W'(b));
  endtask

  task automatic end_test(string name, int errs_before);
    n_tests++;
    if (n_errors == errs_before)
      $display("%s: passed", name);
    else
      $display("%s: failed with %0d errors", name, n_errors - errs_before);
  endtask

  task automatic test_reset_and_first();
    int errs;
    errs = n_errors;
    @(negedge cr_intf);
    check_flag("busy after reset", busy, 1'b0);
    check_mid("rsp_mid after reset", rsp_mid, MID_IDLE);
    run_request("first unsigned", MID_RAST, OP_DIVU, DATA_W'(1000), DATA_W'(7));
    end_test("reset_and_first", errs);
  endtask

  task automatic test_random_unsigned();
    int                errs;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    errs = n_errors;
    for (int i = 0; i < 40; i++)
    begin
      a = DATA_W'($urandom);
      b = DATA_W'($urandom);
      if (i % 2 == 1)
        b = b >> 9;              // Small divisors, long quotients
      if (b == '0)
        b = DATA_W'(1);
      run_request("random unsigned", pick_mid($urandom), OP_DIVU, a, b);
    end
    end_test("random_unsigned", errs);
  endtask

  task automatic test_signed();
    int                errs;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    errs = n_errors;
    run_signed(MID_TEX, 100, 7);
    run_signed(MID_TEX, -100, 7);
    run_signed(MID_HOST, 100, -7);
    run_signed(MID_HOST, -100, -7);
    run_signed(MID_RAST, -32768, -1);  // Overflow
    run_signed(MID_RAST, -32768, 3);
    run_signed(MID_TEX, 32767, -32768);
    run_signed(MID_HOST, 5, -9);       // Zero quotient
    for (int i = 0; i < 8; i++)
    begin
      a = DATA_W'($urandom);
      b = DATA_W'($urandom);
      if (b == '0)
        b = '1;
      run_request("random signed", pick_mid($urandom), OP_DIVS, a, b);
    end
    end_test("signed", errs);
  endtask

  task automatic test_zero_divisor();
    int errs;
    errs = n_errors;
    run_request("unsigned zero divisor", MID_RAST, OP_DIVU, DATA_W'(16'h1234), '0);
    run_request("signed zero divisor", MID_TEX, OP_DIVS, DATA_W'(-300), '0);
    run_request("after zero divisor", MID_HOST, OP_DIVS, DATA_W'(-300), DATA_W'(7));
    end_test("zero_divisor", errs);
  endtask

  task automatic test_busy_drop();
    int                errs;
    int                n_rsp;
    int                k;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    errs  = n_errors;
    n_rsp = 0;
    a     = DATA_W'(50000);
    b     = DATA_W'(123);
    issue_request(MID_TEX, OP_DIVU, {a, b});
    for (k = 1; k <= 25; k++)
    begin
      @(posedge cr_intf);
      if (k == 3)
      begin
        req_mid  <= MID_HOST;    // Lands mid divide
        req_op   <= OP_DIVS;
        req_data <= {DATA_W'(9), DATA_W'(3)};
      end
      else
        req_mid <= MID_IDLE;
      @(negedge cr_intf);
      if (k <= 10)
        check_flag("busy while dividing", busy, 1'b1);
      if (k == RSP_LATENCY)
        check_flag("busy at response", busy, 1'b0);
      if (rsp_mid != MID_IDLE)
      begin
        n_rsp++;
        check_latency("busy drop", k);
        check_mid("busy drop", rsp_mid, MID_TEX);
        check_word("busy drop", rsp_data, expected_word(OP_DIVU, a, b));
      end
    end
    if (n_rsp != 1)
    begin
      n_errors++;
      $display("Request during busy: %0d responses seen where exactly one was expected", n_rsp);
    end
    end_test("busy_drop", errs);
  endtask

  initial
  begin
    void'($urandom(17668));
    reset    = 1'b1;
    req_mid  = MID_IDLE;
    req_op   = OP_DIVU;
    req_data = '0;
    repeat (10) @(posedge cr_intf);
    reset <= 1'b0;
    test_reset_and_first();
    test_random_unsigned();
    test_signed();
    test_zero_divisor();
    test_busy_drop();
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
gpu_global_pkg.sv
gpu_div_pkg.sv
gpu_div_intf.sv
gpu_div_decode.sv
gpu_div_execute.sv
gpu_div_result.sv
gpu_div_top.sv
gpu_div_assertions.sv
tb_gpu_div.sv

/* Makefile */
# Verilator build and run of the divide unit testbench
TOP := tb_gpu_div

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
